// ==== logic/insn_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module insn_decoder import phoenix_pkg::*; (
	input  logic       clk_g,
	input  logic       rst_i,
	input  logic       acc_valid_i,
	input  insn_t      acc_insn_i,
	input  code_addr_t acc_ip_i,
	input  thread_id_t acc_thread_i,
	output logic       dec_valid_o,
	output decode_t    dec_o,
	output code_addr_t dec_ip_o,
	output thread_id_t dec_thread_o,
	output reg_addr_t  rd_ra_o,
	output reg_addr_t  rd_rb_o,
	output reg_addr_t  rd_rt_o,
	output reg_addr_t  rd_rm_o
);

	insn_t insn_q;

	// Stage register
	always_ff @(posedge clk_g) begin
		if (rst_i)
			dec_valid_o <= 1'b0;
		else
			dec_valid_o <= acc_valid_i;
	end

	always_ff @(posedge clk_g) begin
		insn_q <= acc_insn_i;
		dec_ip_o <= acc_ip_i;
		dec_thread_o <= acc_thread_i;
	end

	// Register file addresses straight from the word
	assign rd_ra_o = insn_q.ra;
	assign rd_rb_o = insn_q.rb;
	assign rd_rt_o = insn_q.rt;
	assign rd_rm_o = insn_q.rm;

	// Opcode to flags, anything unknown becomes NOP
	always_comb begin
		dec_o = '0;
		dec_o.opcode = NOP;
		case (insn_q.opcode)
			ADD, SUB, AND, OR, XOR, ADDI: begin
				dec_o.opcode = opcode_e'(insn_q.opcode);
				dec_o.wr = 1'b1;
			end
			JMP: begin
				dec_o.opcode = JMP;
				dec_o.is_jump = 1'b1;
			end
			BEQ: begin
				dec_o.opcode = BEQ;
				dec_o.is_branch = 1'b1;
			end
			default: ;
		endcase
		dec_o.ta = insn_q.ta;
		dec_o.tb = insn_q.tb;
		// Vector target only for ops that write
		dec_o.tt = insn_q.tt & dec_o.wr;
		// Lane mask only means something on a vector target
		dec_o.m = insn_q.m & dec_o.tt;
		dec_o.rt = insn_q.rt;
		dec_o.imm = {{24{insn_q.imm[7]}}, insn_q.imm};
	end

endmodule

`default_nettype wire

// ==== logic/lane_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_alu import phoenix_pkg::*; #(
	parameter int NLANES = phoenix_pkg::NLANES
) (
	input  slot_t      slot_i,
	output vec_value_t result_o,
	output code_addr_t next_ip_o
);

	code_addr_t base_ip;
	code_addr_t seq_ip;
	code_addr_t offset;

	// ============================================================
	// Lane-wise ALU
	// ============================================================
	always_comb begin
		for (int l = 0; l < NLANES; l++) begin
			case (slot_i.dec.opcode)
				ADD:     result_o[l] = slot_i.a[l] + slot_i.b[l];
				SUB:     result_o[l] = slot_i.a[l] - slot_i.b[l];
				AND:     result_o[l] = slot_i.a[l] & slot_i.b[l];
				OR:      result_o[l] = slot_i.a[l] | slot_i.b[l];
				XOR:     result_o[l] = slot_i.a[l] ^ slot_i.b[l];
				ADDI:    result_o[l] = slot_i.a[l] + slot_i.dec.imm;
				// Jumps, branches and NOP produce no data
				default: result_o[l] = '0;
			endcase
		end
	end

	// ============================================================
	// Next instruction pointer
	// ============================================================

	// Thread base is the ip rounded down to its region
	assign base_ip = slot_i.ip & ~code_addr_t'(THREAD_SPAN - 1);
	assign seq_ip = slot_i.ip + code_addr_t'(INSN_BYTES);
	// Immediate counts instructions, not bytes
	assign offset = slot_i.dec.imm << 2;

	always_comb begin
		if (slot_i.dec.is_jump) begin
			// Absolute within the thread region
			next_ip_o = base_ip + offset;
		end else if (slot_i.dec.is_branch) begin
			// Compare lane 0 only
			if (slot_i.a[0] == slot_i.b[0])
				next_ip_o = slot_i.ip + offset;
			else
				next_ip_o = seq_ip;
		end else begin
			next_ip_o = seq_ip;
		end
	end

endmodule

`default_nettype wire

// ==== logic/phoenix_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module phoenix_core import phoenix_pkg::*; #(
	parameter int NTHREADS = phoenix_pkg::NTHREADS,
	parameter int NLANES   = phoenix_pkg::NLANES
) (
	input  logic       clk_g,
	input  logic       rst_i,
	input  insn_t      insn_i,
	input  logic       insn_valid_i,
	output code_addr_t fetch_ip_o,
	output thread_id_t fetch_thread_o,
	output logic       commit_valid_o,
	output thread_id_t commit_thread_o,
	output code_addr_t commit_ip_o,
	output logic       commit_wr_o,
	output logic       commit_vec_o,
	output reg_addr_t  commit_tgt_o,
	output vec_value_t commit_data_o
);

	// Fetch to decode
	logic acc_valid;
	insn_t acc_insn;
	code_addr_t acc_ip;
	thread_id_t acc_thread;

	// Decode to register files and slots
	logic dec_valid;
	decode_t dec;
	code_addr_t dec_ip;
	thread_id_t dec_thread;
	reg_addr_t rd_ra, rd_rb, rd_rt, rd_rm;
	value_t sc_rdata0, sc_rdata1, sc_rdata2;
	vec_value_t vec_rdata0, vec_rdata1, vec_rdata2;

	// Execute and retire
	slot_t ex_slot;
	vec_value_t alu_result;
	code_addr_t alu_next_ip;
	logic redirect_valid, release_valid;
	thread_id_t redirect_thread, release_thread;
	code_addr_t redirect_ip;
	logic scalar_wr, vector_wr;
	thread_id_t wr_thread;
	reg_addr_t wr_addr;
	value_t scalar_wdata;
	vec_value_t vector_wdata;

	thread_fetch #(.NTHREADS(NTHREADS)) fetch_i (
		.clk_g, .rst_i, .insn_i, .insn_valid_i,
		.redirect_valid_i(redirect_valid), .redirect_thread_i(redirect_thread),
		.redirect_ip_i(redirect_ip),
		.release_valid_i(release_valid), .release_thread_i(release_thread),
		.fetch_ip_o, .fetch_thread_o,
		.acc_valid_o(acc_valid), .acc_insn_o(acc_insn),
		.acc_ip_o(acc_ip), .acc_thread_o(acc_thread)
	);

	insn_decoder decoder_i (
		.clk_g, .rst_i,
		.acc_valid_i(acc_valid), .acc_insn_i(acc_insn),
		.acc_ip_i(acc_ip), .acc_thread_i(acc_thread),
		.dec_valid_o(dec_valid), .dec_o(dec), .dec_ip_o(dec_ip), .dec_thread_o(dec_thread),
		.rd_ra_o(rd_ra), .rd_rb_o(rd_rb), .rd_rt_o(rd_rt), .rd_rm_o(rd_rm)
	);

	// Scalar file, third port reads the mask register
	thread_regfile #(.entry_t(value_t), .NTHREADS(NTHREADS)) scalar_rf_i (
		.clk_g, .rst_i,
		.wr_i(scalar_wr), .wthread_i(wr_thread), .waddr_i(wr_addr), .wdata_i(scalar_wdata),
		.rthread_i(dec_thread), .raddr0_i(rd_ra), .raddr1_i(rd_rb), .raddr2_i(rd_rm),
		.rdata0_o(sc_rdata0), .rdata1_o(sc_rdata1), .rdata2_o(sc_rdata2)
	);

	// Vector file, third port reads the old target
	thread_regfile #(.entry_t(vec_value_t), .NTHREADS(NTHREADS)) vector_rf_i (
		.clk_g, .rst_i,
		.wr_i(vector_wr), .wthread_i(wr_thread), .waddr_i(wr_addr), .wdata_i(vector_wdata),
		.rthread_i(dec_thread), .raddr0_i(rd_ra), .raddr1_i(rd_rb), .raddr2_i(rd_rt),
		.rdata0_o(vec_rdata0), .rdata1_o(vec_rdata1), .rdata2_o(vec_rdata2)
	);

	thread_slot_table #(.NTHREADS(NTHREADS), .NLANES(NLANES)) slots_i (
		.clk_g, .rst_i,
		.dec_valid_i(dec_valid), .dec_i(dec), .dec_ip_i(dec_ip), .dec_thread_i(dec_thread),
		.scalar_rdata0_i(sc_rdata0), .scalar_rdata1_i(sc_rdata1), .scalar_rdata2_i(sc_rdata2),
		.vector_rdata0_i(vec_rdata0), .vector_rdata1_i(vec_rdata1),
		.vector_rdata2_i(vec_rdata2),
		.alu_result_i(alu_result), .alu_next_ip_i(alu_next_ip),
		.ex_slot_o(ex_slot),
		.redirect_valid_o(redirect_valid), .redirect_thread_o(redirect_thread),
		.redirect_ip_o(redirect_ip),
		.release_valid_o(release_valid), .release_thread_o(release_thread),
		.scalar_wr_o(scalar_wr), .vector_wr_o(vector_wr),
		.wr_thread_o(wr_thread), .wr_addr_o(wr_addr),
		.scalar_wdata_o(scalar_wdata), .vector_wdata_o(vector_wdata),
		.commit_valid_o, .commit_thread_o, .commit_ip_o, .commit_wr_o,
		.commit_vec_o, .commit_tgt_o, .commit_data_o
	);

	lane_alu #(.NLANES(NLANES)) alu_i (
		.slot_i(ex_slot),
		.result_o(alu_result),
		.next_ip_o(alu_next_ip)
	);

endmodule

`default_nettype wire

// ==== logic/phoenix_pkg.sv ====
`default_nettype none

package phoenix_pkg;

	// ============================================================
	// Core dimensions
	// ============================================================

	// Default thread and lane counts, top level passes them down
	localparam int NTHREADS    = 4;
	localparam int NLANES      = 4;
	localparam int NREGS       = 16;
	// Thread n starts at n * THREAD_SPAN
	localparam int THREAD_SPAN = 256;
	localparam int INSN_BYTES  = 4;

	typedef logic [31:0] value_t;
	typedef value_t [NLANES-1:0] vec_value_t;
	typedef logic [NLANES-1:0] lane_mask_t;
	typedef logic [$clog2(NTHREADS)-1:0] thread_id_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [31:0] code_addr_t;

	// ============================================================
	// Instruction set
	// ============================================================

	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		ADDI = 4'd6,
		JMP  = 4'd7,
		BEQ  = 4'd8
	} opcode_e;

	// Word layout, most significant field first
	typedef struct packed {
		logic [3:0]        opcode;
		reg_addr_t         rt;
		reg_addr_t         ra;
		reg_addr_t         rb;
		reg_addr_t         rm;
		logic              ta;
		logic              tb;
		logic              tt;
		logic              m;
		logic signed [7:0] imm;
	} insn_t;

	// Decoded form carried along with the slot
	typedef struct packed {
		opcode_e   opcode;
		logic      ta;
		logic      tb;
		logic      m;
		logic      tt;
		logic      wr;
		logic      is_jump;
		logic      is_branch;
		reg_addr_t rt;
		value_t    imm;
	} decode_t;

	// One in-flight instruction per thread
	typedef struct packed {
		logic       decoded;
		logic       out;
		logic       executed;
		code_addr_t ip;
		decode_t    dec;
		vec_value_t a;
		vec_value_t b;
		vec_value_t t;
		lane_mask_t mask;
		vec_value_t result;
		code_addr_t new_ip;
	} slot_t;

endpackage

`default_nettype wire

// ==== logic/thread_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module thread_fetch import phoenix_pkg::*; #(
	parameter int NTHREADS = phoenix_pkg::NTHREADS
) (
	input  logic       clk_g,
	input  logic       rst_i,
	input  insn_t      insn_i,
	input  logic       insn_valid_i,
	input  logic       redirect_valid_i,
	input  thread_id_t redirect_thread_i,
	input  code_addr_t redirect_ip_i,
	input  logic       release_valid_i,
	input  thread_id_t release_thread_i,
	output code_addr_t fetch_ip_o,
	output thread_id_t fetch_thread_o,
	output logic       acc_valid_o,
	output insn_t      acc_insn_o,
	output code_addr_t acc_ip_o,
	output thread_id_t acc_thread_o
);

	// Per-thread instruction pointers and in-flight flags
	code_addr_t ip_q [NTHREADS];
	logic [NTHREADS-1:0] busy_q;
	thread_id_t rr_q;
	logic fetch_live_q;

	// Copy of last cycle's request, lines up with the returned word
	logic req_valid_q;
	code_addr_t req_ip_q;
	thread_id_t req_thread_q;

	// Take the word only if it is still the thread's next one
	assign acc_valid_o = req_valid_q && insn_valid_i && !busy_q[req_thread_q]
		&& (req_ip_q == ip_q[req_thread_q]);
	assign acc_insn_o = insn_i;
	assign acc_ip_o = req_ip_q;
	assign acc_thread_o = req_thread_q;

	// ============================================================
	// Round-robin request and thread state
	// ============================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			rr_q <= '0;
			fetch_live_q <= 1'b0;
			req_valid_q <= 1'b0;
			busy_q <= '0;
			fetch_ip_o <= '0;
			fetch_thread_o <= '0;
			for (int n = 0; n < NTHREADS; n++)
				ip_q[n] <= code_addr_t'(n * THREAD_SPAN);
		end else begin
			// One request per cycle, thread order 0, 1, 2, ...
			fetch_live_q <= 1'b1;
			fetch_thread_o <= rr_q;
			fetch_ip_o <= ip_q[rr_q];
			rr_q <= (rr_q == thread_id_t'(NTHREADS - 1)) ? '0 : rr_q + 1'b1;
			req_valid_q <= fetch_live_q;
			// Accepted word, step past it and lock the thread
			if (acc_valid_o) begin
				ip_q[req_thread_q] <= req_ip_q + code_addr_t'(INSN_BYTES);
				busy_q[req_thread_q] <= 1'b1;
			end
			// Taken jump or branch from execute
			if (redirect_valid_i)
				ip_q[redirect_thread_i] <= redirect_ip_i;
			// Retired, thread may fetch again
			if (release_valid_i)
				busy_q[release_thread_i] <= 1'b0;
		end
	end

	always_ff @(posedge clk_g) begin
		req_ip_q <= fetch_ip_o;
		req_thread_q <= fetch_thread_o;
	end

	// Accepted thread stays locked on the next cycle
	a_accept_locks: assert property (@(posedge clk_g) disable iff (rst_i)
		acc_valid_o |=> busy_q[$past(acc_thread_o)]);

endmodule

`default_nettype wire

// ==== logic/thread_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module thread_regfile import phoenix_pkg::*; #(
	parameter type entry_t = value_t,
	parameter int NTHREADS = phoenix_pkg::NTHREADS
) (
	input  logic       clk_g,
	input  logic       rst_i,
	input  logic       wr_i,
	input  thread_id_t wthread_i,
	input  reg_addr_t  waddr_i,
	input  entry_t     wdata_i,
	input  thread_id_t rthread_i,
	input  reg_addr_t  raddr0_i,
	input  reg_addr_t  raddr1_i,
	input  reg_addr_t  raddr2_i,
	output entry_t     rdata0_o,
	output entry_t     rdata1_o,
	output entry_t     rdata2_o
);

	localparam int DEPTH = NTHREADS * NREGS;

	// Thread id in the upper index bits
	entry_t mem_q [DEPTH];

	// Reads are asynchronous
	assign rdata0_o = mem_q[{rthread_i, raddr0_i}];
	assign rdata1_o = mem_q[{rthread_i, raddr1_i}];
	assign rdata2_o = mem_q[{rthread_i, raddr2_i}];

	// Single write port, driven at retirement
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			for (int n = 0; n < DEPTH; n++)
				mem_q[n] <= '0;
		end else if (wr_i) begin
			mem_q[{wthread_i, waddr_i}] <= wdata_i;
		end
	end

	// Writeback must present a real target
	a_waddr_known: assert property (@(posedge clk_g) disable iff (rst_i)
		wr_i |-> !$isunknown({wthread_i, waddr_i}));

endmodule

`default_nettype wire

// ==== logic/thread_slot_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module thread_slot_table import phoenix_pkg::*; #(
	parameter int NTHREADS = phoenix_pkg::NTHREADS,
	parameter int NLANES   = phoenix_pkg::NLANES
) (
	input  logic       clk_g,
	input  logic       rst_i,
	input  logic       dec_valid_i,
	input  decode_t    dec_i,
	input  code_addr_t dec_ip_i,
	input  thread_id_t dec_thread_i,
	input  value_t     scalar_rdata0_i,
	input  value_t     scalar_rdata1_i,
	input  value_t     scalar_rdata2_i,
	input  vec_value_t vector_rdata0_i,
	input  vec_value_t vector_rdata1_i,
	input  vec_value_t vector_rdata2_i,
	input  vec_value_t alu_result_i,
	input  code_addr_t alu_next_ip_i,
	output slot_t      ex_slot_o,
	output logic       redirect_valid_o,
	output thread_id_t redirect_thread_o,
	output code_addr_t redirect_ip_o,
	output logic       release_valid_o,
	output thread_id_t release_thread_o,
	output logic       scalar_wr_o,
	output logic       vector_wr_o,
	output thread_id_t wr_thread_o,
	output reg_addr_t  wr_addr_o,
	output value_t     scalar_wdata_o,
	output vec_value_t vector_wdata_o,
	output logic       commit_valid_o,
	output thread_id_t commit_thread_o,
	output code_addr_t commit_ip_o,
	output logic       commit_wr_o,
	output logic       commit_vec_o,
	output reg_addr_t  commit_tgt_o,
	output vec_value_t commit_data_o
);

	slot_t slots_q [NTHREADS];
	slot_t cap_slot;
	slot_t wb_slot;
	vec_value_t merged;
	logic [NTHREADS-1:0] dec_vec, out_vec, exe_vec;
	thread_id_t pick_idx, x_idx, wb_idx;
	logic pick_valid, x_valid, wb_valid;

	// Lowest set thread wins
	function automatic thread_id_t lowest(input logic [NTHREADS-1:0] v);
		thread_id_t idx;
		idx = '0;
		for (int n = NTHREADS - 1; n >= 0; n--)
			if (v[n])
				idx = thread_id_t'(n);
		return idx;
	endfunction

	always_comb begin
		for (int n = 0; n < NTHREADS; n++) begin
			dec_vec[n] = slots_q[n].decoded;
			out_vec[n] = slots_q[n].out;
			exe_vec[n] = slots_q[n].executed;
		end
	end

	// Three pickers: issue, ALU, retire
	assign pick_valid = |dec_vec;
	assign pick_idx = lowest(dec_vec);
	assign x_valid = |out_vec;
	assign x_idx = lowest(out_vec);
	assign wb_valid = |exe_vec;
	assign wb_idx = lowest(exe_vec);

	// Operand capture, scalar reads fan out to every lane
	always_comb begin
		cap_slot = '0;
		cap_slot.decoded = 1'b1;
		cap_slot.ip = dec_ip_i;
		cap_slot.dec = dec_i;
		cap_slot.a = dec_i.ta ? vector_rdata0_i : {NLANES{scalar_rdata0_i}};
		cap_slot.b = dec_i.tb ? vector_rdata1_i : {NLANES{scalar_rdata1_i}};
		cap_slot.t = vector_rdata2_i;
		cap_slot.mask = dec_i.m ? scalar_rdata2_i[NLANES-1:0] : '1;
	end

	// ============================================================
	// Execute, the out slot sits in front of the ALU
	// ============================================================
	assign ex_slot_o = slots_q[x_idx];
	assign redirect_valid_o = x_valid
		&& (alu_next_ip_i != ex_slot_o.ip + code_addr_t'(INSN_BYTES));
	assign redirect_thread_o = x_idx;
	assign redirect_ip_o = alu_next_ip_i;

	// ============================================================
	// Writeback and commit
	// ============================================================
	always_comb begin
		wb_slot = slots_q[wb_idx];
		// Masked-off lanes keep the old target
		for (int l = 0; l < NLANES; l++)
			merged[l] = wb_slot.mask[l] ? wb_slot.result[l] : wb_slot.t[l];
	end

	assign release_valid_o = wb_valid;
	assign release_thread_o = wb_idx;
	assign scalar_wr_o = wb_valid && wb_slot.dec.wr && !wb_slot.dec.tt;
	assign vector_wr_o = wb_valid && wb_slot.dec.wr && wb_slot.dec.tt;
	assign wr_thread_o = wb_idx;
	assign wr_addr_o = wb_slot.dec.rt;
	assign scalar_wdata_o = merged[0];
	assign vector_wdata_o = merged;

	assign commit_valid_o = wb_valid;
	assign commit_thread_o = wb_idx;
	assign commit_ip_o = wb_slot.ip;
	assign commit_wr_o = wb_slot.dec.wr;
	assign commit_vec_o = wb_slot.dec.tt;
	assign commit_tgt_o = wb_slot.dec.rt;
	assign commit_data_o = merged;

	// Slot state moves decoded, out, executed, empty
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			for (int n = 0; n < NTHREADS; n++) begin
				slots_q[n].decoded <= 1'b0;
				slots_q[n].out <= 1'b0;
				slots_q[n].executed <= 1'b0;
			end
		end else begin
			if (dec_valid_i)
				slots_q[dec_thread_i] <= cap_slot;
			if (pick_valid) begin
				slots_q[pick_idx].decoded <= 1'b0;
				slots_q[pick_idx].out <= 1'b1;
			end
			if (x_valid) begin
				slots_q[x_idx].out <= 1'b0;
				slots_q[x_idx].executed <= 1'b1;
				slots_q[x_idx].result <= alu_result_i;
				slots_q[x_idx].new_ip <= alu_next_ip_i;
			end
			if (wb_valid)
				slots_q[wb_idx].executed <= 1'b0;
		end
	end

	a_state_excl: assert property (@(posedge clk_g) disable iff (rst_i)
		(dec_vec & exe_vec) == '0);

	// Fetch keeps one instruction per thread, so capture finds the slot free
	a_capture_empty: assert property (@(posedge clk_g) disable iff (rst_i)
		dec_valid_i |-> !(dec_vec[dec_thread_i] || out_vec[dec_thread_i]
		|| exe_vec[dec_thread_i]));

endmodule

`default_nettype wire

// ==== project.f ====
logic/phoenix_pkg.sv
logic/thread_fetch.sv
logic/insn_decoder.sv
logic/thread_regfile.sv
logic/thread_slot_table.sv
logic/lane_alu.sv
logic/phoenix_core.sv
verification/phoenix_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the phoenix_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f project.f --top-module phoenix_core_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vphoenix_core_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished cleanly"
exit 0

// ==== verification/core_input.txt ====
# P <byte address hex> <instruction word hex>
# C <thread> <ip hex> <wr> <vec> <tgt> <lane0 hex> <lane1 hex> <lane2 hex> <lane3 hex>
# Thread 0 scalar ALU ops
P 000 61000005
P 004 620000FD
P 008 13120000
P 00C 24120000
P 010 55120000
P 014 36120000
P 018 47430000
# Thread 1 vector ops with scalar broadcast
P 100 61000007
P 104 62100203
P 108 63200A01
P 10C 14310A00
P 110 25420E00
# Thread 2 masked vector writes
P 200 61000005
P 204 62000209
P 208 62001320
P 20C 13220E00
P 210 62000002
P 214 53312B00
# Thread 3 jump, branch not taken, branch taken, skipped words at 308 and 31C
P 300 61000003
P 304 70000004
P 308 6110007F
P 310 80100003
P 314 62000003
P 318 80120002
P 31C 61000055
P 320 631000FF
C 0 000 1 0 1 00000005 00000005 00000005 00000005
C 0 004 1 0 2 FFFFFFFD FFFFFFFD FFFFFFFD FFFFFFFD
C 0 008 1 0 3 00000002 00000002 00000002 00000002
C 0 00C 1 0 4 00000008 00000008 00000008 00000008
C 0 010 1 0 5 FFFFFFF8 FFFFFFF8 FFFFFFF8 FFFFFFF8
C 0 014 1 0 6 00000005 00000005 00000005 00000005
C 0 018 1 0 7 0000000A 0000000A 0000000A 0000000A
C 1 100 1 0 1 00000007 00000007 00000007 00000007
C 1 104 1 1 2 0000000A 0000000A 0000000A 0000000A
C 1 108 1 1 3 0000000B 0000000B 0000000B 0000000B
C 1 10C 1 1 4 00000012 00000012 00000012 00000012
C 1 110 1 1 5 00000008 00000008 00000008 00000008
C 2 200 1 0 1 00000005 00000005 00000005 00000005
C 2 204 1 1 2 00000009 00000009 00000009 00000009
C 2 208 1 1 2 00000020 00000009 00000020 00000009
C 2 20C 1 1 3 00000040 00000012 00000040 00000012
C 2 210 1 0 2 00000002 00000002 00000002 00000002
C 2 214 1 1 3 00000040 00000017 00000040 00000012
C 3 300 1 0 1 00000003 00000003 00000003 00000003
C 3 304 0 0 0 00000000 00000000 00000000 00000000
C 3 310 0 0 0 00000000 00000000 00000000 00000000
C 3 314 1 0 2 00000003 00000003 00000003 00000003
C 3 318 0 0 0 00000000 00000000 00000000 00000000
C 3 320 1 0 3 00000002 00000002 00000002 00000002

// ==== verification/phoenix_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module phoenix_core_tb import phoenix_pkg::*; ();

	localparam int CLK_HALF = 10;
	localparam int CYCLES_PER_COMMIT = 40;
	// 4 KB of code space, covers all four thread regions
	localparam int MEM_WORDS = 1024;

	// One expected retirement
	typedef struct packed {
		code_addr_t ip;
		logic       wr;
		logic       vec;
		reg_addr_t  tgt;
		vec_value_t data;
	} commit_rec_t;

	logic clk_g;
	logic rst_i;
	insn_t insn_i;
	logic insn_valid_i;
	code_addr_t fetch_ip_o;
	thread_id_t fetch_thread_o;
	logic commit_valid_o;
	thread_id_t commit_thread_o;
	code_addr_t commit_ip_o;
	logic commit_wr_o;
	logic commit_vec_o;
	reg_addr_t commit_tgt_o;
	vec_value_t commit_data_o;

	insn_t imem [MEM_WORDS];
	logic [MEM_WORDS-1:0] loaded;
	commit_rec_t exp_q [NTHREADS][$];
	int commit_total;
	int commit_seen;
	int fetch_cycles;
	logic load_done;
	logic [31:0] lcg_state;

	phoenix_core #(.NTHREADS(NTHREADS), .NLANES(NLANES)) phoenix_core_i (
		.clk_g, .rst_i, .insn_i, .insn_valid_i,
		.fetch_ip_o, .fetch_thread_o,
		.commit_valid_o, .commit_thread_o, .commit_ip_o, .commit_wr_o,
		.commit_vec_o, .commit_tgt_o, .commit_data_o
	);

	// 20 ns clock
	always #CLK_HALF clk_g = ~clk_g;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ============================================================
	// Compare tasks, one per result kind
	// ============================================================
	task automatic check_ip(input string name, input code_addr_t got, input code_addr_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_thread(input string name, input thread_id_t got, input thread_id_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_data(input string name, input vec_value_t got, input vec_value_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// ============================================================
	// Program and expected commits from the data file
	// ============================================================
	task automatic load_program();
		int fd;
		int n;
		int th;
		int wr;
		int vec;
		int tgt;
		string line;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] ip;
		logic [31:0] lane [4];
		commit_rec_t rec;
		// Unloaded words are NOPs carrying their own byte address
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = insn_t'(32'(i) << 2);
			loaded[i] = 1'b0;
		end
		commit_total = 0;
		fd = $fopen("verification/core_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verification/core_input.txt");
			$display("TEST FAILED");
			$fatal(1, "No stimulus file");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// Lines that start with anything else are comments
			if (n > 0 && line.getc(0) == "P") begin
				n = $sscanf(line, "P %h %h", addr, word);
				imem[addr[11:2]] = insn_t'(word);
				loaded[addr[11:2]] = 1'b1;
			end else if (n > 0 && line.getc(0) == "C") begin
				n = $sscanf(line, "C %d %h %d %d %d %h %h %h %h", th, ip, wr, vec, tgt,
					lane[0], lane[1], lane[2], lane[3]);
				if (n != 9 || th < 0 || th >= NTHREADS) begin
					$display("Malformed commit line in the stimulus file: %s", line);
					$display("TEST FAILED");
					$fatal(1, "Bad stimulus");
				end
				rec.ip = ip;
				rec.wr = wr[0];
				rec.vec = vec[0];
				rec.tgt = reg_addr_t'(tgt);
				for (int l = 0; l < NLANES; l++)
					rec.data[l] = lane[l];
				exp_q[th].push_back(rec);
				commit_total++;
			end
		end
		$fclose(fd);
		if (commit_total == 0) begin
			$display("The stimulus file lists no expected commits");
			$display("TEST FAILED");
			$fatal(1, "Empty stimulus");
		end
	endtask

	// ============================================================
	// Instruction memory, answers one cycle after the request
	// ============================================================
	always @(posedge clk_g) begin : memory_model
		logic [9:0] widx;
		widx = fetch_ip_o[11:2];
		lcg_state = lcg_next(lcg_state);
		insn_i <= imem[widx];
		// Miss on a zero pair from the upper state bits
		// low bits of the LCG itself repeat every 4 steps
		insn_valid_i <= loaded[widx] && (lcg_state[17:16] != 2'b00);
	end

	// Request thread walks 0, 1, 2, ... from the first cycle after reset
	always @(negedge clk_g) begin : fetch_order_check
		if (rst_i) begin
			fetch_cycles = 0;
		end else begin
			// First sample after reset still shows the reset value
			if (fetch_cycles > 0)
				check_thread("fetch_thread_o", fetch_thread_o,
					thread_id_t'((fetch_cycles - 1) % NTHREADS));
			fetch_cycles++;
		end
	end

	// Commit outputs settle after the edge, sample in the middle
	always @(negedge clk_g) begin : commit_check
		commit_rec_t rec;
		if (!rst_i && commit_valid_o) begin
			if (exp_q[commit_thread_o].size() == 0) begin
				$display("Thread %0d committed ip %h at %0t ns after its list ran out",
					commit_thread_o, commit_ip_o, $time);
				$display("TEST FAILED");
				$fatal(1, "Extra commit");
			end else begin
				rec = exp_q[commit_thread_o].pop_front();
				check_ip("commit_ip_o", commit_ip_o, rec.ip);
				check_flag("commit_wr_o", commit_wr_o, rec.wr);
				check_flag("commit_vec_o", commit_vec_o, rec.vec);
				check_reg("commit_tgt_o", commit_tgt_o, rec.tgt);
				check_data("commit_data_o", commit_data_o, rec.data);
				commit_seen++;
			end
		end
	end

	// Hang guard scaled to the number of expected commits
	initial begin : watchdog
		wait (load_done);
		repeat (commit_total * CYCLES_PER_COMMIT) @(posedge clk_g);
		$display("Timeout, the core hangs with %0d of %0d commits seen",
			commit_seen, commit_total);
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		clk_g = 1'b0;
		rst_i = 1'b1;
		insn_i = '0;
		insn_valid_i = 1'b0;
		lcg_state = 32'd27;
		commit_seen = 0;
		fetch_cycles = 0;
		load_done = 1'b0;
		load_program();
		load_done = 1'b1;
		// Two cycles of reset
		repeat (2) @(posedge clk_g);
		rst_i <= 1'b0;
		wait (commit_seen == commit_total);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
